// ==== Makefile ====
# Verilator build for the sample logger
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= sample_logger_tb
RTL_TOP   ?= sample_logger
FILELIST  ?= sample_logger.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== block_ram.sv ====
`include "sample_logger_defines.svh"

module block_ram #(
    parameter DATA_WIDTH       = `SL_DATA_WIDTH,
    parameter DATA_DEPTH       = `SL_DEPTH,
    parameter PIPELINED_OUTPUT = `SL_PIPELINED_OUTPUT
)(
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            write_enable,
    input  sample_logger_pkg::sample_t      write_data,
    input  sample_logger_pkg::sample_addr_t write_address,
    input  sample_logger_pkg::sample_addr_t read_address,

    output sample_logger_pkg::sample_t      read_data
);

    logic [DATA_WIDTH-1:0] memory [DATA_DEPTH];
    logic [DATA_WIDTH-1:0] memory_read_data;

    // Write port and registered read port share the clock
    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_address] <= write_data;
        end
        memory_read_data <= memory[read_address];
    end

    generate
        if (PIPELINED_OUTPUT) begin : g_output_register
            logic [DATA_WIDTH-1:0] output_register;

            always_ff @(posedge clock) begin
                if (rst) begin
                    output_register <= '0;
                end else begin
                    output_register <= memory_read_data;
                end
            end

            assign read_data = output_register;
        end else begin : g_direct_output
            assign read_data = memory_read_data;
        end
    endgenerate

    // Writes must land inside the array
    write_address_in_range: assert property (
        @(posedge clock) disable iff (rst)
        write_enable |-> (int'(write_address) < DATA_DEPTH)
    );

endmodule

// ==== capture_control.sv ====
`include "sample_logger_defines.svh"

module capture_control (
    input  logic                               clock,
    input  logic                               rst,
    input  logic                               arm,
    input  logic                               sample_valid,
    input  sample_logger_pkg::sample_t         sample_data,
    input  logic                               trigger,

    output logic                               write_enable,
    output sample_logger_pkg::sample_addr_t    write_address,
    output sample_logger_pkg::sample_t         write_data,
    output sample_logger_pkg::capture_window_t window,
    output sample_logger_pkg::capture_state_t  state
);

    // Last count value of each counted phase
    localparam sample_logger_pkg::sample_addr_t PREFILL_LAST =
        sample_logger_pkg::sample_addr_t'(`SL_PRE_TRIGGER - 1);
    localparam sample_logger_pkg::sample_addr_t POST_LAST =
        sample_logger_pkg::sample_addr_t'(`SL_DEPTH - `SL_PRE_TRIGGER - 2);
    localparam sample_logger_pkg::sample_addr_t PRE_TRIGGER_OFFSET =
        sample_logger_pkg::sample_addr_t'(`SL_PRE_TRIGGER);

    sample_logger_pkg::sample_addr_t write_pointer;
    sample_logger_pkg::sample_addr_t sample_count;
    sample_logger_pkg::sample_addr_t window_start;
    logic                            trigger_accepted;

    //////////////////////////////
    // RAM write side
    //////////////////////////////

    assign write_enable = sample_valid &&
                          ((state == sample_logger_pkg::CAP_PREFILL) ||
                           (state == sample_logger_pkg::CAP_ARMED)   ||
                           (state == sample_logger_pkg::CAP_POST));
    assign write_address = write_pointer;
    assign write_data    = sample_data;

    // Trigger only counts alongside a sample once armed
    assign trigger_accepted = (state == sample_logger_pkg::CAP_ARMED) && sample_valid && trigger;

    //////////////////////////////
    // Capture sequencing
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            state         <= sample_logger_pkg::CAP_IDLE;
            write_pointer <= '0;
            sample_count  <= '0;
        end else if (arm) begin
            // Restart from any state
            state         <= sample_logger_pkg::CAP_PREFILL;
            write_pointer <= '0;
            sample_count  <= '0;
        end else begin
            // Wraps at the RAM depth
            if (write_enable) begin
                write_pointer <= write_pointer + 1'b1;
            end

            case (state)
                sample_logger_pkg::CAP_PREFILL: begin
                    if (sample_valid) begin
                        if (sample_count == PREFILL_LAST) begin
                            state        <= sample_logger_pkg::CAP_ARMED;
                            sample_count <= '0;
                        end else begin
                            sample_count <= sample_count + 1'b1;
                        end
                    end
                end
                sample_logger_pkg::CAP_ARMED: begin
                    if (trigger_accepted) begin
                        state        <= sample_logger_pkg::CAP_POST;
                        sample_count <= '0;
                    end
                end
                sample_logger_pkg::CAP_POST: begin
                    if (sample_valid) begin
                        if (sample_count == POST_LAST) begin
                            state <= sample_logger_pkg::CAP_DONE;
                        end else begin
                            sample_count <= sample_count + 1'b1;
                        end
                    end
                end
                default: begin
                    // Idle and done wait for arm
                end
            endcase
        end
    end

    // Window begins the pre-trigger length ahead of the trigger sample
    always_ff @(posedge clock) begin
        if (trigger_accepted) begin
            window_start <= write_pointer - PRE_TRIGGER_OFFSET;
        end
    end

    assign window.valid         = (state == sample_logger_pkg::CAP_DONE);
    assign window.start_address = window_start;

    //////////////////////////////
    // Checks
    //////////////////////////////

    // A finished window spans the whole RAM, so the next write would land on its start
    window_full_at_done: assert property (
        @(posedge clock) disable iff (rst)
        window.valid |-> (write_pointer == window_start)
    );

    done_holds_until_arm: assert property (
        @(posedge clock) disable iff (rst)
        (state == sample_logger_pkg::CAP_DONE) && !arm |=> (state == sample_logger_pkg::CAP_DONE)
    );

endmodule

// ==== readout_port.sv ====
`include "sample_logger_defines.svh"

module readout_port #(
    parameter READ_LATENCY = `SL_READ_LATENCY
)(
    input  logic                               clock,
    input  logic                               rst,
    input  sample_logger_pkg::capture_window_t window,
    input  logic                               read_request,
    input  sample_logger_pkg::sample_addr_t    read_offset,

    output sample_logger_pkg::sample_addr_t    read_address,
    output logic                               read_valid
);

    logic                    request_accepted;
    logic [READ_LATENCY-1:0] valid_pipe;

    // Offset into the window, wrapping around the RAM
    assign read_address = window.start_address + read_offset;

    // Only a frozen window can be read
    assign request_accepted = read_request && window.valid;

    //////////////////////////////
    // Latency matching
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= request_accepted;
            for (int i = 1; i < READ_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // Lines up with data leaving the RAM
    assign read_valid = valid_pipe[READ_LATENCY-1];

    valid_follows_window: assert property (
        @(posedge clock) disable iff (rst)
        read_valid |-> $past(window.valid, READ_LATENCY)
    );

endmodule

// ==== sample_logger.f ====
+incdir+.
sample_logger_pkg.sv
block_ram.sv
capture_control.sv
readout_port.sv
sample_logger.sv
sample_logger_tb.sv

// ==== sample_logger.sv ====
`include "sample_logger_defines.svh"

module sample_logger (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              arm,
    input  logic                              sample_valid,
    input  sample_logger_pkg::sample_t        sample_data,
    input  logic                              trigger,
    input  logic                              read_request,
    input  sample_logger_pkg::sample_addr_t   read_offset,

    output sample_logger_pkg::sample_t        read_data,
    output logic                              read_valid,
    output sample_logger_pkg::capture_state_t capture_state
);

    logic                               write_enable;
    sample_logger_pkg::sample_addr_t    write_address;
    sample_logger_pkg::sample_t         write_data;
    sample_logger_pkg::sample_addr_t    read_address;
    sample_logger_pkg::capture_window_t window;

    capture_control capture_control_i (
        .clock         (clock),
        .rst           (rst),
        .arm           (arm),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .trigger       (trigger),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data),
        .window        (window),
        .state         (capture_state)
    );

    block_ram #(
        .DATA_WIDTH       (`SL_DATA_WIDTH),
        .DATA_DEPTH       (`SL_DEPTH),
        .PIPELINED_OUTPUT (`SL_PIPELINED_OUTPUT)
    ) block_ram_i (
        .clock         (clock),
        .rst           (rst),
        .write_enable  (write_enable),
        .write_data    (write_data),
        .write_address (write_address),
        .read_address  (read_address),
        .read_data     (read_data)
    );

    readout_port #(
        .READ_LATENCY (`SL_READ_LATENCY)
    ) readout_port_i (
        .clock        (clock),
        .rst          (rst),
        .window       (window),
        .read_request (read_request),
        .read_offset  (read_offset),
        .read_address (read_address),
        .read_valid   (read_valid)
    );

endmodule

// ==== sample_logger_defines.svh ====
`ifndef SAMPLE_LOGGER_DEFINES_SVH
`define SAMPLE_LOGGER_DEFINES_SVH

//////////////////////////////
// Sample and memory geometry
//////////////////////////////

`define SL_DATA_WIDTH       16
`define SL_DEPTH            256
`define SL_ADDR_WIDTH       8

// Samples kept ahead of the trigger sample
`define SL_PRE_TRIGGER      64

//////////////////////////////
// Read path
//////////////////////////////

// 1 adds a register behind the RAM read port
`define SL_PIPELINED_OUTPUT 1
`define SL_READ_LATENCY     (1 + `SL_PIPELINED_OUTPUT)

`endif

// ==== sample_logger_pkg.sv ====
`include "sample_logger_defines.svh"

package sample_logger_pkg;

    // One sensor sample as it sits in the RAM
    typedef logic [`SL_DATA_WIDTH-1:0] sample_t;

    // Physical RAM address, or offset inside the recorded window
    typedef logic [`SL_ADDR_WIDTH-1:0] sample_addr_t;

    // Capture sequence
    typedef enum logic [2:0] {
        CAP_IDLE,
        CAP_PREFILL,
        CAP_ARMED,
        CAP_POST,
        CAP_DONE
    } capture_state_t;

    // Frozen window handed to the readout side
    typedef struct packed {
        logic         valid;
        sample_addr_t start_address;
    } capture_window_t;

endpackage

// ==== sample_logger_tb.sv ====
`include "sample_logger_defines.svh"

module sample_logger_tb;

    localparam int DEPTH       = `SL_DEPTH;
    localparam int PRE_TRIGGER = `SL_PRE_TRIGGER;
    // A handful of captures with their reads needs a few thousand cycles
    localparam int CYCLE_LIMIT = 20000;
    localparam int DRIVE_DELAY = 2;

    logic                              clock;
    logic                              rst;
    logic                              arm;
    logic                              sample_valid;
    sample_logger_pkg::sample_t        sample_data;
    logic                              trigger;
    logic                              read_request;
    sample_logger_pkg::sample_addr_t   read_offset;
    sample_logger_pkg::sample_t        read_data;
    logic                              read_valid;
    sample_logger_pkg::capture_state_t capture_state;

    // Reference model: samples since the last arm and the trigger position
    sample_logger_pkg::sample_t sent_samples[$];
    int                         trigger_index;
    bit                         window_complete;
    int                         cycle_count = 0;
    string                      test_name;

    sample_logger dut_i (
        .clock         (clock),
        .rst           (rst),
        .arm           (arm),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .trigger       (trigger),
        .read_request  (read_request),
        .read_offset   (read_offset),
        .read_data     (read_data),
        .read_valid    (read_valid),
        .capture_state (capture_state)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Simulation timed out");
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic tick();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    // A trigger counts once the prefill is full and no trigger has counted yet
    task automatic record_sample(input sample_logger_pkg::sample_t data, input bit trig);
        if (!window_complete) begin
            if (trig && trigger_index < 0 && sent_samples.size() >= PRE_TRIGGER) begin
                trigger_index = sent_samples.size();
            end
            sent_samples.push_back(data);
            if (trigger_index >= 0 && sent_samples.size() == trigger_index + DEPTH - PRE_TRIGGER) begin
                window_complete = 1'b1;
            end
        end
    endtask

    task automatic arm_logger();
        arm = 1'b1;
        tick();
        arm = 1'b0;
        sent_samples.delete();
        trigger_index   = -1;
        window_complete = 1'b0;
        check_equal("state after arm", 32'(sample_logger_pkg::CAP_PREFILL), 32'(capture_state));
    endtask

    task automatic send_sample(input sample_logger_pkg::sample_t data, input bit trig);
        sample_valid = 1'b1;
        sample_data  = data;
        trigger      = trig;
        record_sample(data, trig);
        tick();
        sample_valid = 1'b0;
        trigger      = 1'b0;
    endtask

    task automatic send_samples(input int base, input int count, input int trigger_at);
        for (int n = 0; n < count; n++) begin
            send_sample(sample_logger_pkg::sample_t'(base + n), n == trigger_at);
        end
    endtask

    // Sends a ramp until the model says the window is full
    task automatic run_capture(input int base, input int first_trigger,
                               input int second_trigger, input bit with_gaps);
        int n = 0;
        while (!window_complete) begin
            if (with_gaps && ($urandom % 3 == 0)) begin
                // Idle cycle, sometimes with a lone trigger pulse
                trigger = 1'($urandom % 2);
                tick();
                trigger = 1'b0;
            end else begin
                send_sample(sample_logger_pkg::sample_t'(base + n),
                            (n == first_trigger) || (n == second_trigger));
                n++;
            end
        end
        check_equal("state after last sample", 32'(sample_logger_pkg::CAP_DONE),
                    32'(capture_state));
    endtask

    // Back to back reads; each response is due two cycles after its request
    task automatic read_window();
        int expected_index;
        for (int i = 0; i <= DEPTH + 1; i++) begin
            read_request = (i < DEPTH);
            read_offset  = sample_logger_pkg::sample_addr_t'(i);
            tick();
            check_equal("read_valid", 32'(i >= 1 && i <= DEPTH), 32'(read_valid));
            if (i >= 1 && i <= DEPTH) begin
                expected_index = trigger_index - PRE_TRIGGER + i - 1;
                check_equal("read_data", 32'(sent_samples[expected_index]), 32'(read_data));
            end
        end
        read_request = 1'b0;
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reset();
        test_name = "reset";
        check_equal("state", 32'(sample_logger_pkg::CAP_IDLE), 32'(capture_state));
        check_equal("read_valid", 32'(0), 32'(read_valid));
        for (int i = 0; i < 6; i++) begin
            read_request = (i < 4);
            read_offset  = sample_logger_pkg::sample_addr_t'(i);
            tick();
            check_equal("read_valid without window", 32'(0), 32'(read_valid));
        end
        read_request = 1'b0;
    endtask

    task automatic test_full_capture();
        test_name = "full_capture";
        arm_logger();
        run_capture(16'h1000, 100, -1, 1'b0);
        read_window();
    endtask

    task automatic test_prefill_trigger();
        test_name = "prefill_trigger";
        arm_logger();
        run_capture(16'h2000, 20, 130, 1'b0);
        read_window();
    endtask

    task automatic test_sample_gaps();
        test_name = "sample_gaps";
        arm_logger();
        run_capture(16'h3000, 90, -1, 1'b1);
        read_window();
    endtask

    task automatic test_rearm();
        test_name = "rearm";
        arm_logger();
        send_samples(16'h4000, PRE_TRIGGER + 50, PRE_TRIGGER);
        check_equal("state before rearm", 32'(sample_logger_pkg::CAP_POST), 32'(capture_state));
        arm_logger();
        run_capture(16'h5000, 100, -1, 1'b0);
        read_window();
    endtask

    task automatic test_frozen_window();
        test_name = "frozen_window";
        send_samples(16'hf000, 40, 10);
        check_equal("state after extra samples", 32'(sample_logger_pkg::CAP_DONE),
                    32'(capture_state));
        read_window();
    endtask

    initial begin
        void'($urandom(31));
        rst             = 1'b1;
        arm             = 1'b0;
        sample_valid    = 1'b0;
        sample_data     = '0;
        trigger         = 1'b0;
        read_request    = 1'b0;
        read_offset     = '0;
        trigger_index   = -1;
        window_complete = 1'b0;
        test_name       = "startup";
        repeat (10) @(posedge clock);
        #DRIVE_DELAY;
        rst = 1'b0;

        test_reset();
        test_full_capture();
        test_prefill_trigger();
        test_sample_gaps();
        test_rearm();
        test_frozen_window();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
